// ==== verilog/memTestPkg.sv ====
/*
 * Memory exerciser shared definitions
 * Default widths, display geometry, script length and port select type
 */

package memTestPkg;

	// Default RAM word width
	localparam int dataWidth = 16;

	// Default RAM address width, 1024 words
	localparam int addrWidth = 10;

	// Number of steps in the fixed script
	localparam int stepCount = 6;

	// Hex digits shown on the display
	localparam int digitCount = 4;

	// Segments per digit, a through g
	localparam int segWidth = 7;

	// Which RAM port feeds the display
	typedef enum logic {
		portA = 1'b0,
		portB = 1'b1
	} portSel;

endpackage

// ==== verilog/dualPortRam.sv ====
/*
 * True dual-port block RAM with registered read-first ports
 * Powers up with every word holding its address plus one
 */

`timescale 1ns/1ps

module dualPortRam #(
	parameter int dataWidth = memTestPkg::dataWidth,
	parameter int addrWidth = memTestPkg::addrWidth
) (
	input  logic                 clk,
	input  logic [addrWidth-1:0] addressA,
	input  logic [addrWidth-1:0] addressB,
	input  logic [dataWidth-1:0] dataInA,
	input  logic [dataWidth-1:0] dataInB,
	input  logic                 weA,
	input  logic                 weB,
	output logic [dataWidth-1:0] dataOutA,
	output logic [dataWidth-1:0] dataOutB
);

	// Full address space
	localparam int depth = 1 << addrWidth;

	// Storage array
	logic [dataWidth-1:0] mem [0:depth-1];

	// Power-up contents
	// Word n holds n plus one so every read is nonzero
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = dataWidth'(i + 1);
		end
	end

	// Both ports in one process
	// Reads sample the old word since writes are nonblocking
	always_ff @(posedge clk) begin
		// Port A read
		dataOutA <= mem[addressA];

		// Port B read
		dataOutB <= mem[addressB];

		// Port A write
		if (weA) begin
			mem[addressA] <= dataInA;
		end

		// Port B write
		// Script never writes both ports at one address
		if (weB) begin
			mem[addressB] <= dataInB;
		end
	end

endmodule

// ==== verilog/memoryExerciser.sv ====
/*
 * Memory exerciser sequencer
 * Runs the fixed six-step read/write script on both RAM ports per request
 */

`timescale 1ns/1ps

module memoryExerciser import memTestPkg::*; #(
	parameter int dataWidth = memTestPkg::dataWidth,
	parameter int addrWidth = memTestPkg::addrWidth
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 req,
	output logic                 ack,
	output logic [addrWidth-1:0] addressA,
	output logic [addrWidth-1:0] addressB,
	output logic [dataWidth-1:0] dataInA,
	output logic [dataWidth-1:0] dataInB,
	output logic                 weA,
	output logic                 weB,
	output portSel               displaySelect,
	output logic                 readValid
);

	// RAM read plus display register
	localparam int pipeDepth = 2;

	// Step count at which ack is raised
	localparam int lastStep = stepCount + pipeDepth;
	localparam int stepBits = $clog2(lastStep + 1);

	typedef enum logic [1:0] {
		stateIdle,
		stateRun,
		stateDone
	} stateT;

	stateT state;
	logic [stepBits-1:0] step;

	// Current step is a script step, not pipeline drain
	logic inScript;

	// Decoded drives for the current step
	logic [addrWidth-1:0] stepAddrA;
	logic [addrWidth-1:0] stepAddrB;
	logic [dataWidth-1:0] stepDataA;
	logic [dataWidth-1:0] stepDataB;
	logic                 stepWeA;
	logic                 stepWeB;
	portSel               stepSelect;

	// Select and valid issued with the addresses
	portSel issueSelect;
	logic   issueValid;

	assign inScript = (state == stateRun) && (step < stepBits'(stepCount));

	// Script decode
	// Each step reads one port and may write the other
	always_comb begin
		stepAddrA  = '0;
		stepAddrB  = '0;
		stepDataA  = '0;
		stepDataB  = '0;
		stepWeA    = 1'b0;
		stepWeB    = 1'b0;
		stepSelect = portA;
		case (step)
			// Read A at 0
			stepBits'(0): begin
				stepAddrA  = addrWidth'(0);
				stepSelect = portA;
			end
			// Read B at 1
			stepBits'(1): begin
				stepAddrB  = addrWidth'(1);
				stepSelect = portB;
			end
			// Read B at 2, write 4 to 0 on A
			stepBits'(2): begin
				stepAddrB  = addrWidth'(2);
				stepAddrA  = addrWidth'(0);
				stepDataA  = dataWidth'(4);
				stepWeA    = 1'b1;
				stepSelect = portB;
			end
			// Read back 0 on A, write 5 to 600 on B
			stepBits'(3): begin
				stepAddrA  = addrWidth'(0);
				stepAddrB  = addrWidth'(600);
				stepDataB  = dataWidth'(5);
				stepWeB    = 1'b1;
				stepSelect = portA;
			end
			// Read back 600 on A, put 1 back at 0 on B
			stepBits'(4): begin
				stepAddrA  = addrWidth'(600);
				stepAddrB  = addrWidth'(0);
				stepDataB  = dataWidth'(1);
				stepWeB    = 1'b1;
				stepSelect = portA;
			end
			// Read B at 5, clear 600 on A
			stepBits'(5): begin
				stepAddrB  = addrWidth'(5);
				stepAddrA  = addrWidth'(600);
				stepDataA  = dataWidth'(0);
				stepWeA    = 1'b1;
				stepSelect = portB;
			end
			default: begin
				stepSelect = portA;
			end
		endcase
	end

	// Control FSM and step counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateIdle;
			step  <= '0;
			ack   <= 1'b0;
		end else begin
			case (state)
				stateIdle: begin
					if (req) begin
						state <= stateRun;
						step  <= '0;
					end
				end
				// Six script steps then two drain cycles
				stateRun: begin
					if (step == stepBits'(lastStep)) begin
						state <= stateDone;
						ack   <= 1'b1;
					end else begin
						step <= step + 1'b1;
					end
				end
				// Hold ack until the requester lets go
				stateDone: begin
					if (!req) begin
						state <= stateIdle;
						ack   <= 1'b0;
					end
				end
				default: begin
					state <= stateIdle;
				end
			endcase
		end
	end

	// Write enables, valid and select pipeline
	always_ff @(posedge clk) begin
		if (rst) begin
			weA           <= 1'b0;
			weB           <= 1'b0;
			issueValid    <= 1'b0;
			issueSelect   <= portA;
			readValid     <= 1'b0;
			displaySelect <= portA;
		end else begin
			weA           <= inScript && stepWeA;
			weB           <= inScript && stepWeB;
			issueValid    <= inScript;
			issueSelect   <= stepSelect;
			// One more stage to meet the RAM output
			readValid     <= issueValid;
			displaySelect <= issueSelect;
		end
	end

	// Address and write data registers
	always_ff @(posedge clk) begin
		addressA <= stepAddrA;
		addressB <= stepAddrB;
		dataInA  <= stepDataA;
		dataInB  <= stepDataB;
	end

endmodule

// ==== verilog/resultDisplay.sv ====
/*
 * Result display
 * Registers the selected RAM read word and decodes it to hex segments
 */

`timescale 1ns/1ps

module resultDisplay import memTestPkg::*; #(
	parameter int dataWidth = memTestPkg::dataWidth
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [dataWidth-1:0]           dataOutA,
	input  logic [dataWidth-1:0]           dataOutB,
	input  portSel                         displaySelect,
	input  logic                           readValid,
	output logic [dataWidth-1:0]           shown,
	output logic                           shownValid,
	output logic [digitCount*segWidth-1:0] segments
);

	// Hex nibble to segments, bit 0 is a, bit 6 is g
	function automatic logic [segWidth-1:0] hexToSeg(input logic [3:0] nibble);
		logic [segWidth-1:0] seg;
		case (nibble)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c;
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e;
			4'he: seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

	// Capture only valid reads, hold the last word otherwise
	always_ff @(posedge clk) begin
		if (rst) begin
			shown      <= '0;
			shownValid <= 1'b0;
		end else begin
			shownValid <= readValid;
			if (readValid) begin
				shown <= (displaySelect == portB) ? dataOutB : dataOutA;
			end
		end
	end

	// Digit 0 is the low nibble
	always_comb begin
		for (int d = 0; d < digitCount; d++) begin
			segments[d*segWidth +: segWidth] = hexToSeg(shown[d*4 +: 4]);
		end
	end

endmodule

// ==== verilog/memoryTest.sv ====
/*
 * Memory test top level
 * Exerciser drives the dual-port RAM, display shows the chosen read word
 */

`timescale 1ns/1ps

module memoryTest import memTestPkg::*; #(
	parameter int dataWidth = memTestPkg::dataWidth,
	parameter int addrWidth = memTestPkg::addrWidth
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           req,
	output logic                           ack,
	output logic [dataWidth-1:0]           shown,
	output logic                           shownValid,
	output logic [digitCount*segWidth-1:0] segments
);

	// RAM port drives
	logic [addrWidth-1:0] addressA;
	logic [addrWidth-1:0] addressB;
	logic [dataWidth-1:0] dataInA;
	logic [dataWidth-1:0] dataInB;
	logic                 weA;
	logic                 weB;

	// RAM read data
	logic [dataWidth-1:0] dataOutA;
	logic [dataWidth-1:0] dataOutB;

	// Display control, aligned with the read data
	portSel displaySelect;
	logic   readValid;

	memoryExerciser #(
		.dataWidth(dataWidth),
		.addrWidth(addrWidth)
	) memoryExerciser_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.addressA(addressA),
		.addressB(addressB),
		.dataInA(dataInA),
		.dataInB(dataInB),
		.weA(weA),
		.weB(weB),
		.displaySelect(displaySelect),
		.readValid(readValid)
	);

	dualPortRam #(
		.dataWidth(dataWidth),
		.addrWidth(addrWidth)
	) dualPortRam_i (
		.clk(clk),
		.addressA(addressA),
		.addressB(addressB),
		.dataInA(dataInA),
		.dataInB(dataInB),
		.weA(weA),
		.weB(weB),
		.dataOutA(dataOutA),
		.dataOutB(dataOutB)
	);

	resultDisplay #(
		.dataWidth(dataWidth)
	) resultDisplay_i (
		.clk(clk),
		.rst(rst),
		.dataOutA(dataOutA),
		.dataOutB(dataOutB),
		.displaySelect(displaySelect),
		.readValid(readValid),
		.shown(shown),
		.shownValid(shownValid),
		.segments(segments)
	);

endmodule

// ==== testbench/memoryTest_chk.sv ====
/*
 * Handshake and valid window checks for the memory test top level
 */

`timescale 1ns/1ps

module memoryTest_chk (
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input logic shownValid
);

	// Length of the current shownValid window
	logic [3:0] validLength;

	// Violation counts, one per rule
	int ackRiseErrors = 0;
	int validLengthErrors = 0;
	int ackFallErrors = 0;

	// Count consecutive valid cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			validLength <= '0;
		end else if (shownValid) begin
			// Saturates so a stuck valid still reads as too long
			if (validLength != 4'hf) begin
				validLength <= validLength + 1'b1;
			end
		end else begin
			validLength <= '0;
		end
	end

	// Ack only answers a request that was present
	ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
		else begin
			$error("ack rose while req was low");
			ackRiseErrors++;
		end

	// Six display words per run
	validWindow: assert property (@(posedge clk) disable iff (rst)
		$fell(shownValid) |-> validLength == 4'd6)
		else begin
			$error("shownValid window was %0d cycles, not six", $sampled(validLength));
			validLengthErrors++;
		end

	// Ack drops on the edge after req is seen low
	ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
		($fell(req) && ack) |=> !ack)
		else begin
			$error("ack stayed high one cycle after req fell");
			ackFallErrors++;
		end

endmodule

bind memoryTest memoryTest_chk handshakeChk_i (
	.clk(clk),
	.rst(rst),
	.req(req),
	.ack(ack),
	.shownValid(shownValid)
);

// ==== testbench/memoryTestTb.sv ====
/*
 * Memory test testbench
 * Four-phase requester with pattern file checks on shown words and segments
 */

`timescale 1ns/1ps

module memoryTestTb import memTestPkg::*; ();

	localparam int clockPeriod = 8;
	localparam int resetCycles = 5;
	// Edge index of the ack rise, counted from the edge that samples req
	localparam int ackLatency = 9;
	localparam int maxGap = 15;
	// Two words per step plus the run count
	localparam int patternWords = 2 * stepCount + 1;

	logic                           clk;
	logic                           rst;
	logic                           req;
	logic                           ack;
	logic [dataWidth-1:0]           shown;
	logic                           shownValid;
	logic [digitCount*segWidth-1:0] segments;

	logic [31:0] patterns [0:patternWords-1];
	int runCount;
	int timeoutLimit = 0;
	int cycleCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	integer seed;

	memoryTest #(
		.dataWidth(dataWidth),
		.addrWidth(addrWidth)
	) memoryTest_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.shown(shown),
		.shownValid(shownValid),
		.segments(segments)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clockPeriod / 2) clk = ~clk;
		end
	end

	// Run limit, armed once the run count is known
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
			$display("Timeout: the run went past %0d cycles without finishing", timeoutLimit);
			$display("tests failed");
			$finish;
		end
	end

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			$display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h",
				$time, what, got, expected);
			errorCount++;
		end
	endtask

	// One line per finished test
	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount > errorsBefore) begin
			failedTests++;
			$display("%s: FAIL, %0d errors", name, errorCount - errorsBefore);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	// One request from idle gap to ack drop
	task automatic runScript(input int runIndex);
		int gap;
		int edgeIndex;
		int validIndex;
		int errorsBefore;
		errorsBefore = errorCount;
		gap = $unsigned($random(seed)) % (maxGap + 1);
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		// Requester may only raise req while ack is low
		checkValue($sformatf("run %0d ack before req", runIndex), 32'(ack), 32'd0);
		req = 1'b1;
		edgeIndex = -1;
		validIndex = 0;
		// Collect display words until ack, global counter bounds the wait
		while (ack !== 1'b1) begin
			@(posedge clk);
			#1;
			edgeIndex++;
			if (shownValid) begin
				if (validIndex < stepCount) begin
					checkValue($sformatf("run %0d step %0d shown", runIndex, validIndex),
						32'(shown), patterns[2*validIndex]);
					checkValue($sformatf("run %0d step %0d segments", runIndex, validIndex),
						32'(segments), patterns[2*validIndex+1]);
				end
				validIndex++;
			end
		end
		checkValue($sformatf("run %0d ack latency", runIndex),
			32'(edgeIndex), 32'(ackLatency));
		checkValue($sformatf("run %0d valid cycles", runIndex),
			32'(validIndex), 32'(stepCount));
		// Release, ack must clear on the next edge
		req = 1'b0;
		@(posedge clk);
		#1;
		checkValue($sformatf("run %0d ack after req drop", runIndex), 32'(ack), 32'd0);
		reportTest($sformatf("run %0d", runIndex), errorsBefore);
	endtask

	initial begin
		int errorsBefore;
		int violations;
		seed = 32'hfbd4_65dd;
		rst = 1'b1;
		req = 1'b0;
		$readmemh("testbench/memoryTestPatterns.txt", patterns);
		runCount = int'(patterns[2 * stepCount]);
		assert (runCount > 0 && runCount < 100) else begin
			$display("Pattern file does not give a usable run count");
			errorCount++;
			runCount = 0;
		end
		// Each run needs at most the gap, the script and the release
		timeoutLimit = runCount * (ackLatency + 2 + maxGap) + 50;

		// Reset and idle outputs
		errorsBefore = errorCount;
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;
		checkValue("ack after reset", 32'(ack), 32'd0);
		checkValue("shownValid after reset", 32'(shownValid), 32'd0);
		checkValue("shown after reset", 32'(shown), 32'd0);
		@(posedge clk);
		#1;
		checkValue("ack while idle", 32'(ack), 32'd0);
		checkValue("shownValid while idle", 32'(shownValid), 32'd0);
		checkValue("shown while idle", 32'(shown), 32'd0);
		reportTest("reset", errorsBefore);

		// Same six words every run if the restoring writes work
		for (int r = 1; r <= runCount; r++) begin
			runScript(r);
		end

		violations = memoryTest_i.handshakeChk_i.ackRiseErrors
			+ memoryTest_i.handshakeChk_i.validLengthErrors
			+ memoryTest_i.handshakeChk_i.ackFallErrors;
		assert (violations == 0) else begin
			$display("Bound handshake assertions reported %0d violations", violations);
			errorCount++;
		end

		$display("%0d tests run, %0d failed, %0d check errors",
			testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
verilog/memTestPkg.sv
verilog/dualPortRam.sv
verilog/memoryExerciser.sv
verilog/resultDisplay.sv
verilog/memoryTest.sv
testbench/memoryTest_chk.sv
testbench/memoryTestTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = memoryTestTb
FILELIST = list.f
PASS     = all tests passed

.PHONY: simulate clean

# Build, run, and fail unless the pass line shows up in the output
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

// ==== testbench/memoryTestPatterns.txt ====
// Columns: shown value, segment code (digit 0 in bits 6:0, segments a to g)
// Six script steps in order, then the number of runs on the last line
0001 07efdf86 // step 0, read A at 0
0002 07efdfdb // step 1, read B at 1
0003 07efdfcf // step 2, read B at 2
0004 07efdfe6 // step 3, read A at 0 after the write
0005 07efdfed // step 4, read A at 600 after the write
0006 07efdffd // step 5, read B at 5
// Runs
4
